//--- verilog/mul_cfg.svh
`ifndef MUL_CFG_SVH
`define MUL_CFG_SVH

// operand width of the core
`define MUL_XLEN 32

// sign-extended multiplicand width, also the number of tree columns
`define MUL_EXT_W 68

// radix-4 Booth over a 34-bit multiplier gives 17 partial products
`define MUL_PP_NUM 17

// carries handed from one Wallace column to the next
`define MUL_CSA_CARRY 14

`endif

//--- verilog/mul_pkg.sv
`default_nettype none

`include "mul_cfg.svh"

package mul_pkg;

    // encoding follows funct3 of the M extension
    typedef enum logic [1:0] {
        MUL_OP_MUL    = 2'b00,
        MUL_OP_MULH   = 2'b01,
        MUL_OP_MULHSU = 2'b10,
        MUL_OP_MULHU  = 2'b11
    } mul_op_e;

    typedef logic [`MUL_PP_NUM-1:0][`MUL_EXT_W-1:0] pp_array_t;  // row j is partial product j

    typedef logic [`MUL_PP_NUM-1:0] pp_col_t;  // one bit from each partial product

    // the low word does not depend on the signs, so MUL may use either
    function automatic logic op_x_signed(input mul_op_e op);
        return op != MUL_OP_MULHU;
    endfunction

    function automatic logic op_y_signed(input mul_op_e op);
        return (op == MUL_OP_MUL) || (op == MUL_OP_MULH);
    endfunction

endpackage

`default_nettype wire

//--- verilog/mul_pp_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "mul_cfg.svh"

interface mul_pp_if;
    import mul_pkg::*;

    pp_array_t              pp;        // registered Booth partial products
    logic [`MUL_PP_NUM-1:0] pp_carry;  // plus-one of each negated partial product
    logic                   valid;     // one-cycle strobe for the data above
    mul_op_e                op;

    modport src (
        output pp,
        output pp_carry,
        output valid,
        output op
    );

    modport dst (
        input pp,
        input pp_carry,
        input valid,
        input op
    );

endinterface

`default_nettype wire

//--- verilog/booth_encoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "mul_cfg.svh"

module booth_encoder (
    input  logic [2:0]            win_i,  // {y[2i+1], y[2i], y[2i-1]}
    input  logic [`MUL_EXT_W-1:0] x_i,
    output logic [`MUL_EXT_W-1:0] pp_o,
    output logic                  neg_o
);

    logic                  sel_x;
    logic                  sel_2x;
    logic [`MUL_EXT_W-1:0] mag;

    always_comb begin
        sel_x  = 1'b0;
        sel_2x = 1'b0;
        neg_o  = 1'b0;
        case (win_i)
            3'b001, 3'b010: sel_x = 1'b1;
            3'b011: sel_2x = 1'b1;
            3'b100: begin
                sel_2x = 1'b1;
                neg_o  = 1'b1;
            end
            3'b101, 3'b110: begin
                sel_x = 1'b1;
                neg_o = 1'b1;
            end
            default: ;  // 000 and 111 both select zero
        endcase
    end

    assign mag  = ({`MUL_EXT_W{sel_x}} & x_i) | ({`MUL_EXT_W{sel_2x}} & (x_i << 1));

    // negative rows are one's complement here and the missing +1 rides on neg_o
    assign pp_o = neg_o ? ~mag : mag;

endmodule

`default_nettype wire

//--- verilog/booth_pp_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "mul_cfg.svh"

module booth_pp_gen (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 valid_i,
    input  mul_pkg::mul_op_e     op_i,
    input  logic [`MUL_XLEN-1:0] x_i,
    input  logic [`MUL_XLEN-1:0] y_i,
    mul_pp_if.src                pp_o
);
    import mul_pkg::*;

    logic                   x_sgn;
    logic                   y_sgn;
    logic [`MUL_EXT_W-1:0]  x_ext;
    logic [`MUL_XLEN+1:0]   y_ext;  // two extra bits so the top window sees the sign
    logic [`MUL_XLEN+2:0]   y_win;
    pp_array_t              pp_d;
    logic [`MUL_PP_NUM-1:0] carry_d;

    assign x_sgn = op_x_signed(op_i) & x_i[`MUL_XLEN-1];
    assign y_sgn = op_y_signed(op_i) & y_i[`MUL_XLEN-1];

    assign x_ext = {{(`MUL_EXT_W-`MUL_XLEN){x_sgn}}, x_i};
    assign y_ext = {{2{y_sgn}}, y_i};
    assign y_win = {y_ext, 1'b0};  // implicit y[-1] is zero

    for (genvar i = 0; i < `MUL_PP_NUM; i++) begin : g_enc
        booth_encoder u_enc (
            .win_i (y_win[2*i+2:2*i]),
            .x_i   (x_ext << (2*i)),
            .pp_o  (pp_d[i]),
            .neg_o (carry_d[i])
        );
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pp_o.valid <= 1'b0;
        end else begin
            pp_o.valid <= valid_i;
        end
    end

    // operand payload only moves when a request comes in
    always_ff @(posedge clk) begin
        if (valid_i) begin
            pp_o.pp       <= pp_d;
            pp_o.pp_carry <= carry_d;
            pp_o.op       <= op_i;
        end
    end

endmodule

`default_nettype wire

//--- verilog/wallace_column.sv
`timescale 1ns/1ns
`default_nettype none

`include "mul_cfg.svh"

module wallace_column (
    input  mul_pkg::pp_col_t          col_i,
    input  logic [`MUL_CSA_CARRY-1:0] cin_i,   // from the next lower column
    output logic [`MUL_CSA_CARRY-1:0] cout_o,  // to the next higher column
    output logic                      c_o,
    output logic                      s_o
);

    logic [4:0]  s1;
    logic [11:0] in2;
    logic [3:0]  s2;
    logic [7:0]  in3;
    logic [1:0]  s3;
    logic [5:0]  in4;
    logic [1:0]  s4;
    logic [3:0]  in5;
    logic        s5;
    logic [2:0]  in6;

    function automatic logic maj3(input logic [2:0] v);
        return (v[0] & v[1]) | (v[0] & v[2]) | (v[1] & v[2]);
    endfunction

    // carries of layer k in this column enter layer k+1 of the next column
    always_comb begin
        for (int k = 0; k < 5; k++) begin
            s1[k]     = ^col_i[3*k +: 3];  // five adders take 15 bits while 2 bits pass through
            cout_o[k] = maj3(col_i[3*k +: 3]);
        end
        in2 = {col_i[16:15], cin_i[4:0], s1};
        for (int k = 0; k < 4; k++) begin
            s2[k]       = ^in2[3*k +: 3];
            cout_o[5+k] = maj3(in2[3*k +: 3]);
        end
        in3 = {cin_i[8:5], s2};
        for (int k = 0; k < 2; k++) begin
            s3[k]       = ^in3[3*k +: 3];  // top two bits wait for the next layer
            cout_o[9+k] = maj3(in3[3*k +: 3]);
        end
        in4 = {cin_i[10:9], in3[7:6], s3};
        for (int k = 0; k < 2; k++) begin
            s4[k]        = ^in4[3*k +: 3];
            cout_o[11+k] = maj3(in4[3*k +: 3]);
        end
        in5        = {cin_i[12:11], s4};
        s5         = ^in5[2:0];
        cout_o[13] = maj3(in5[2:0]);
        in6        = {cin_i[13], in5[3], s5};
        s_o        = ^in6;
        c_o        = maj3(in6);  // this bit has the weight of the next column in the final CPA
    end

endmodule

`default_nettype wire

//--- verilog/wallace_reduce.sv
`timescale 1ns/1ns
`default_nettype none

`include "mul_cfg.svh"

module wallace_reduce (
    mul_pp_if.dst                 pp_i,
    output logic [`MUL_EXT_W-1:0] tree_c_o,
    output logic [`MUL_EXT_W-1:0] tree_s_o
);
    import mul_pkg::*;

    pp_col_t [`MUL_EXT_W-1:0]                     cols;
    logic    [`MUL_EXT_W-1:0][`MUL_CSA_CARRY-1:0] carry_path;  // top entry falls off the word
    logic    [`MUL_EXT_W-1:0][`MUL_CSA_CARRY-1:0] cin;

    // column i collects bit i of every partial product
    always_comb begin
        for (int i = 0; i < `MUL_EXT_W; i++) begin
            for (int j = 0; j < `MUL_PP_NUM; j++) begin
                cols[i][j] = pp_i.pp[j][i];
            end
        end
    end

    // column 0 has no neighbour, so it absorbs the first negate carries
    assign cin = {carry_path[`MUL_EXT_W-2:0], pp_i.pp_carry[`MUL_CSA_CARRY-1:0]};

    for (genvar i = 0; i < `MUL_EXT_W; i++) begin : g_col
        wallace_column u_col (
            .col_i  (cols[i]),
            .cin_i  (cin[i]),
            .cout_o (carry_path[i]),
            .c_o    (tree_c_o[i]),
            .s_o    (tree_s_o[i])
        );
    end

endmodule

`default_nettype wire

//--- verilog/mul_result_sel.sv
`timescale 1ns/1ns
`default_nettype none

`include "mul_cfg.svh"

module mul_result_sel (
    input  logic                  clk,
    input  logic                  rst_n_i,
    mul_pp_if.dst                 pp_i,
    input  logic [`MUL_EXT_W-1:0] tree_c_i,
    input  logic [`MUL_EXT_W-1:0] tree_s_i,
    output logic                  valid_o,
    output logic [`MUL_XLEN-1:0]  result_o
);
    import mul_pkg::*;

    logic [`MUL_EXT_W-1:0] sum;
    logic [`MUL_XLEN-1:0]  word;

    // the tree carries sit one column up, which leaves bit 0 free for another negate carry
    assign sum = {tree_c_i[`MUL_EXT_W-2:0], pp_i.pp_carry[`MUL_CSA_CARRY]}
               + tree_s_i
               + {{(`MUL_EXT_W-1){1'b0}}, pp_i.pp_carry[`MUL_CSA_CARRY+1]};

    // pp_carry[16] is never set because the top window only sees sign or zero bits
    assign word = (pp_i.op == MUL_OP_MUL) ? sum[`MUL_XLEN-1:0]
                                          : sum[2*`MUL_XLEN-1:`MUL_XLEN];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o  <= 1'b0;
            result_o <= '0;
        end else begin
            valid_o <= pp_i.valid;
            if (pp_i.valid) begin
                result_o <= word;  // holds the last result between requests
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/mul_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "mul_cfg.svh"

module mul_unit (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 valid_i,
    input  logic [1:0]           op_i,      // funct3[1:0] of the M extension
    input  logic [`MUL_XLEN-1:0] x_i,
    input  logic [`MUL_XLEN-1:0] y_i,
    output logic                 valid_o,   // two cycles after valid_i
    output logic [`MUL_XLEN-1:0] result_o
);
    import mul_pkg::*;

    logic [`MUL_EXT_W-1:0] tree_c;
    logic [`MUL_EXT_W-1:0] tree_s;

    mul_pp_if u_pp_if ();

    booth_pp_gen u_booth_pp_gen (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (valid_i),
        .op_i    (mul_op_e'(op_i)),
        .x_i     (x_i),
        .y_i     (y_i),
        .pp_o    (u_pp_if.src)
    );

    // purely combinational, sits between the two register stages
    wallace_reduce u_wallace_reduce (
        .pp_i     (u_pp_if.dst),
        .tree_c_o (tree_c),
        .tree_s_o (tree_s)
    );

    mul_result_sel u_mul_result_sel (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .pp_i     (u_pp_if.dst),
        .tree_c_i (tree_c),
        .tree_s_i (tree_s),
        .valid_o  (valid_o),
        .result_o (result_o)
    );

endmodule

`default_nettype wire

//--- test/mul_unit_assert.sv
`timescale 1ns/1ns
`default_nettype none

module mul_unit_assert (
    input wire logic        clk,
    input wire logic        rst_n_i,
    input wire logic        valid_i,
    input wire logic        valid_o,
    input wire logic [31:0] result_o
);

    int fail_cnt = 0;

    // each request yields exactly one result two cycles later
    assert property (@(posedge clk) disable iff (!rst_n_i) valid_o == $past(valid_i, 2))
        else begin
            fail_cnt++;
            $error("valid_o does not follow valid_i by two cycles");
        end

    assert property (@(posedge clk) !rst_n_i |=> !valid_o)
        else begin
            fail_cnt++;
            $error("valid_o is high while reset is held");
        end

    assert property (@(posedge clk) disable iff (!rst_n_i) valid_o |-> !$isunknown(result_o))
        else begin
            fail_cnt++;
            $error("result_o has unknown bits while valid_o is high");
        end

endmodule

`default_nettype wire

//--- test/mul_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "mul_cfg.svh"

module mul_unit_tb;

    logic                 clk = 1'b0;
    logic                 rst_n_i;
    logic                 valid_i;
    logic [1:0]           op_i;
    logic [`MUL_XLEN-1:0] x_i;
    logic [`MUL_XLEN-1:0] y_i;
    logic                 valid_o;
    logic [`MUL_XLEN-1:0] result_o;

    logic [1:0]           op_v [64];
    logic [`MUL_XLEN-1:0] x_v [64];
    logic [`MUL_XLEN-1:0] y_v [64];
    logic [`MUL_XLEN-1:0] exp_v [64];
    logic [`MUL_XLEN-1:0] exp_q [$];  // expected results in issue order
    int                   issue_q [$];  // cycle at which each request was driven
    logic [1:0]           f_op;
    logic [`MUL_XLEN-1:0] f_x;
    logic [`MUL_XLEN-1:0] f_y;
    logic [`MUL_XLEN-1:0] f_exp;
    string                line;
    integer               fd;
    integer               seed;
    int                   vec_num = 0;
    int                   gap;
    int                   wait_cnt;
    int                   total;
    int                   cyc = 0;
    int                   mism_cnt = 0;
    int                   other_cnt = 0;
    logic                 got_any = 1'b0;

    mul_unit u_dut (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .valid_i  (valid_i),
        .op_i     (op_i),
        .x_i      (x_i),
        .y_i      (y_i),
        .valid_o  (valid_o),
        .result_o (result_o)
    );

    bind mul_unit mul_unit_assert u_assert (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .valid_i  (valid_i),
        .valid_o  (valid_o),
        .result_o (result_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mism_cnt++;
            $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!rst_n_i || (!valid_o && !got_any)) begin
            check_value("valid_o", {31'd0, valid_o}, 32'd0);
            check_value("result_o", result_o, 32'd0);
        end else if (valid_o) begin
            got_any = 1'b1;
            if (exp_q.size() == 0) begin
                other_cnt++;
                $display("a result arrived without a pending request");
            end else begin
                check_value("result_o", result_o, exp_q.pop_front());
                check_value("latency", cyc - issue_q.pop_front(), 32'd2);
            end
        end
    end

    initial begin
        rst_n_i = 1'b0;
        valid_i = 1'b0;
        op_i    = 2'd0;
        x_i     = '0;
        y_i     = '0;
        seed    = 62;
        fd = $fopen("test/mul_unit_testdata.txt", "r");
        if (fd == 0) begin
            other_cnt++;
            $display("could not open the test data file");
        end else begin
            while (!$feof(fd) && vec_num < 64) begin
                if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%h %h %h %h", f_op, f_x, f_y, f_exp) == 4) begin
                        op_v[vec_num]  = f_op;
                        x_v[vec_num]   = f_x;
                        y_v[vec_num]   = f_y;
                        exp_v[vec_num] = f_exp;
                        vec_num++;
                    end
                end
            end
            $fclose(fd);
        end
        if (vec_num == 0) begin
            other_cnt++;
            $display("no test vectors were read");
        end
        repeat (4) @(posedge clk);
        #10 rst_n_i = 1'b1;
        for (int i = 0; i < vec_num; i++) begin
            gap = (i >= vec_num - 3) ? 0 : $unsigned($random(seed)) % 4;  // last three back to back
            repeat (gap) begin
                @(posedge clk);
                #10 valid_i = 1'b0;
            end
            @(posedge clk);
            #10;
            valid_i = 1'b1;
            op_i    = op_v[i];
            x_i     = x_v[i];
            y_i     = y_v[i];
            exp_q.push_back(exp_v[i]);
            issue_q.push_back(cyc);
        end
        @(posedge clk);
        #10 valid_i = 1'b0;
        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < 20) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (exp_q.size() != 0) begin
            other_cnt++;
            $display("no result arrived within the timeout");
        end
        repeat (3) @(posedge clk);  // a stray result would still show up here
        total = mism_cnt + other_cnt + u_dut.u_assert.fail_cnt;
        $display("errors: %0d mismatches, %0d other, %0d assertion failures",
                 mism_cnt, other_cnt, u_dut.u_assert.fail_cnt);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/mul_unit_testdata.txt
# op x y expected_result, all in hex
# op 0 MUL, 1 MULH, 2 MULHSU, 3 MULHU
0 ffffffff ffffffff 00000001
0 00001234 fffffffe ffffdb98
0 00000007 fffffff9 ffffffcf
1 80000000 80000000 40000000
1 ffffffff 00000001 ffffffff
1 7fffffff 7fffffff 3fffffff
2 ffffffff ffffffff ffffffff
2 80000000 ffffffff 80000000
2 00000002 80000000 00000001
3 ffffffff ffffffff fffffffe
3 00010000 00010000 00000001
1 fffffffe 00000003 ffffffff
3 fffffffe 00000003 00000002

//--- mul_unit.f
+incdir+verilog
verilog/mul_pkg.sv
verilog/mul_pp_if.sv
verilog/booth_encoder.sv
verilog/booth_pp_gen.sv
verilog/wallace_column.sv
verilog/wallace_reduce.sv
verilog/mul_result_sel.sv
verilog/mul_unit.sv
test/mul_unit_assert.sv
test/mul_unit_tb.sv

//--- Bender.yml
package:
  name: mul_unit

export_include_dirs:
  - verilog

sources:
  - verilog/mul_pkg.sv
  - verilog/mul_pp_if.sv
  - verilog/booth_encoder.sv
  - verilog/booth_pp_gen.sv
  - verilog/wallace_column.sv
  - verilog/wallace_reduce.sv
  - verilog/mul_result_sel.sv
  - verilog/mul_unit.sv
  - target: test
    files:
      - test/mul_unit_assert.sv
      - test/mul_unit_tb.sv
